// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = memUartBusTb
FILELIST = memUartBus.f
OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJDIR)

// ==== dv/chipModels.sv ====
module sramModel (
	input  busPkg::memAddrT ramAddr,
	input  logic en,
	input  logic oe,
	input  logic we,
	inout  wire busPkg::memValueT ramData
);

	import busPkg::*;

	memValueT mem [0:(1 << AddrWidth) - 1];

	assign ramData = (!en && !oe) ? mem[ramAddr] : 'z;

	// Word stored as the write strobe ends
	always @(posedge we) begin
		if (!en) begin
			mem[ramAddr] <= ramData;
		end
	end

endmodule

module uartModel (
	input  logic clk,
	input  logic rdn,
	input  logic wrn,
	inout  wire busPkg::memValueT ramData,
	output logic dataReady,
	output logic tbre,
	output logic tsre,
	output logic [7:0] lastSent,
	output int sentCount,
	output logic [7:0] lastServed
);

	logic [7:0] offerByte;

	// Only the low byte is real, upper byte reads as zero
	assign ramData = !rdn ? {8'h00, offerByte} : 'z;

	//////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////

	initial begin
		tbre = 1'b1;
		tsre = 1'b1;
		lastSent = '0;
		sentCount = 0;
		forever begin
			@(negedge wrn);
			tbre = 1'b0;
			tsre = 1'b0;
			@(posedge wrn);
			lastSent = ramData[7:0];
			sentCount++;
			repeat (1 + $urandom % 8) @(negedge clk);
			tbre = 1'b1;
			repeat ($urandom % 8) @(negedge clk);
			tsre = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////

	initial begin
		dataReady = 1'b0;
		offerByte = '0;
		lastServed = '0;
		forever begin
			repeat (1 + $urandom % 12) @(negedge clk);
			offerByte = 8'($urandom);
			dataReady = 1'b1;
			@(negedge rdn);
			dataReady = 1'b0;
			@(posedge rdn);
			lastServed = offerByte;
		end
	end

endmodule

// ==== dv/memUartBusTb.sv ====
module memUartBusTb;

	import busPkg::*;

	localparam memAddrT UartAddr = 18'h0BF00;
	localparam int ResetCycles = 16;
	localparam int RamCount = 20;
	localparam int UartWrCount = 8;
	localparam int UartRdCount = 8;
	localparam int MixCount = 40;
	localparam int AccessTotal = 2 * RamCount + UartWrCount + UartRdCount + MixCount;

	logic clk;
	logic rst;
	logic needToWork;
	memReqT req;
	logic cfgWrite;
	paceDivT cfgDiv;
	logic workDone;
	memValueT result;
	busStateT state;
	memAddrT ramAddr;
	wire memValueT ramData;
	sramPinsT sramPins;
	uartPinsT uartPins;
	logic dataReady;
	logic tbre;
	logic tsre;
	logic [7:0] lastSent;
	int sentCount;
	logic [7:0] lastServed;
	logic sawTbre;
	logic sawTsre;

	// Reference model state
	memValueT ramModel [memAddrT];
	memAddrT usedAddrs [$];
	logic [7:0] sentQ [$];
	logic [7:0] rcvdQ [$];
	int errorCount;
	int checkCount;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	memUartBus dut (
		.clk(clk),
		.rst(rst),
		.needToWork(needToWork),
		.req(req),
		.workDone(workDone),
		.result(result),
		.state(state),
		.cfgWrite(cfgWrite),
		.cfgDiv(cfgDiv),
		.ramAddr(ramAddr),
		.ramData(ramData),
		.sramPins(sramPins),
		.uartPins(uartPins),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

	sramModel sram (
		.ramAddr(ramAddr),
		.en(sramPins.en),
		.oe(sramPins.oe),
		.we(sramPins.we),
		.ramData(ramData)
	);

	uartModel uart (
		.clk(clk),
		.rdn(uartPins.rdn),
		.wrn(uartPins.wrn),
		.ramData(ramData),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre),
		.lastSent(lastSent),
		.sentCount(sentCount),
		.lastServed(lastServed)
	);

	// Both flags must be seen high after the write strobe ends
	always @(posedge clk) begin
		if (!uartPins.wrn) begin
			sawTbre <= 1'b0;
			sawTsre <= 1'b0;
		end else begin
			sawTbre <= sawTbre | tbre;
			sawTsre <= sawTsre | tsre;
		end
	end

	//////////////////////////////////////////////////
	// Checks and bus access tasks
	//////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCount++;
		assert (cond) else begin
			$display("Error at %0t: %s", $time, what);
			errorCount++;
		end
	endtask

	// Done stays high until the next start, so see it fall first
	task automatic waitDone();
		while (workDone) begin
			@(posedge clk);
			#1;
		end
		do begin
			@(posedge clk);
			#1;
		end while (!workDone);
	endtask

	task automatic runAccess(input logic rd, input logic wr, input memAddrT addr,
		input memValueT value);
		req = '{rd: rd, wr: wr, addr: addr, value: value};
		needToWork = 1'b1;
		waitDone();
		needToWork = 1'b0;
	endtask

	function automatic memAddrT pickRamAddr();
		memAddrT addr;
		if (usedAddrs.size() > 0 && $urandom % 4 == 0) begin
			addr = usedAddrs[$urandom % usedAddrs.size()];
		end else begin
			do begin
				addr = memAddrT'($urandom);
			end while (addr == UartAddr);
		end
		return addr;
	endfunction

	task automatic ramWrite(input memAddrT addr, input memValueT value);
		runAccess(1'b0, 1'b1, addr, value);
		if (!ramModel.exists(addr)) begin
			usedAddrs.push_back(addr);
		end
		ramModel[addr] = value;
	endtask

	task automatic ramRead(input memAddrT addr);
		runAccess(1'b1, 1'b0, addr, memValueT'($urandom));
		checkValue("result", 32'(result), 32'(ramModel[addr]));
	endtask

	task automatic uartWrite(input memValueT value);
		sentQ.push_back(value[7:0]);
		runAccess(1'b0, 1'b1, UartAddr, value);
		checkValue("sentCount", 32'(sentCount), 32'(sentQ.size()));
		checkValue("lastSent", 32'(lastSent), 32'(sentQ[sentQ.size() - 1]));
		checkTrue(sawTbre && sawTsre, "workDone rose before tbre and tsre were high");
	endtask

	task automatic uartRead();
		runAccess(1'b1, 1'b0, UartAddr, memValueT'($urandom));
		rcvdQ.push_back(lastServed);
		checkValue("result", 32'(result), 32'(rcvdQ[rcvdQ.size() - 1]));
	endtask

	task automatic reloadDiv(input paceDivT div);
		cfgDiv = div;
		cfgWrite = 1'b1;
		@(posedge clk);
		#1;
		cfgWrite = 1'b0;
	endtask

	task automatic finishTest(input string name, input int errBefore);
		$display("%s finished, %0d errors", name, errorCount - errBefore);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int errBefore;
		int pick;
		memAddrT tmp;
		memAddrT order [$];
		void'($urandom(51062));
		rst = 1'b0;
		needToWork = 1'b0;
		req = '0;
		cfgWrite = 1'b0;
		cfgDiv = '0;
		errorCount = 0;
		checkCount = 0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		rst = 1'b1;

		errBefore = errorCount;
		checkValue("sramPins", 32'(sramPins), 32'h7);
		checkValue("uartPins", 32'(uartPins), 32'h3);
		checkValue("workDone", 32'(workDone), 32'h0);
		checkValue("state", 32'(state), 32'(Idle));
		finishTest("Test 1 reset values", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < RamCount; i++) begin
			ramWrite(pickRamAddr(), memValueT'($urandom));
		end
		order = usedAddrs;
		for (int i = order.size() - 1; i > 0; i--) begin
			pick = int'($urandom % (i + 1));
			tmp = order[i];
			order[i] = order[pick];
			order[pick] = tmp;
		end
		foreach (order[i]) begin
			ramRead(order[i]);
		end
		finishTest("Test 2 RAM write and read back", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < UartWrCount; i++) begin
			uartWrite(memValueT'($urandom));
		end
		finishTest("Test 3 UART writes", errBefore);

		errBefore = errorCount;
		for (int i = 0; i < UartRdCount; i++) begin
			uartRead();
		end
		finishTest("Test 4 UART reads", errBefore);

		// Pace changes between accesses
		errBefore = errorCount;
		for (int i = 0; i < MixCount; i++) begin
			if (i == 0 || $urandom % 3 == 0) begin
				reloadDiv(paceDivT'($urandom));
			end
			case ($urandom % 4)
				0: ramWrite(pickRamAddr(), memValueT'($urandom));
				1: ramRead(usedAddrs[$urandom % usedAddrs.size()]);
				2: uartWrite(memValueT'($urandom));
				default: uartRead();
			endcase
		end
		finishTest("Test 5 mixed accesses with pace reloads", errBefore);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (ResetCycles + AccessTotal * 200) @(posedge clk);
		$display("Timeout: accesses did not finish within %0d cycles", AccessTotal * 200);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== dv/memUartBus_assertions.sv ====
module memUartBusAssertions (
	input  logic clk,
	input  logic rst,
	input  logic workDone,
	input  busPkg::busStateT state,
	input  busPkg::sramPinsT sramPins,
	input  busPkg::uartPinsT uartPins
);

	import busPkg::*;

	weOeApart: assert property (@(posedge clk) disable iff (!rst)
		!(!sramPins.we && !sramPins.oe))
		else $error("SRAM we and oe low at the same time");

	// SRAM and UART share the data bus
	ramUartApart: assert property (@(posedge clk) disable iff (!rst)
		!(!sramPins.en && (!uartPins.rdn || !uartPins.wrn)))
		else $error("SRAM enabled during a UART strobe");

	doneInIdle: assert property (@(posedge clk) disable iff (!rst)
		$rose(workDone) |-> state == Idle)
		else $error("workDone rose while the state was not Idle");

endmodule

bind memUartBus memUartBusAssertions busChecks (
	.clk(clk),
	.rst(rst),
	.workDone(workDone),
	.state(state),
	.sramPins(sramPins),
	.uartPins(uartPins)
);

// ==== hdl/busPaceRegs.sv ====
module busPaceRegs #(
	parameter busPkg::paceDivT ResetDiv = 4'd1
) (
	input  logic clk,
	input  logic rst,
	input  logic cfgWrite,
	input  busPkg::paceDivT cfgDiv,
	output logic tick
);

	import busPkg::*;

	paceDivT div;
	paceDivT cnt;
	logic cntZero;

	//////////////////////////////////////////////////
	// Divider register
	//////////////////////////////////////////////////

	// Reloadable at run time from the config port
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div <= ResetDiv;
		end else if (cfgWrite) begin
			div <= cfgDiv;
		end
	end

	//////////////////////////////////////////////////
	// Down-counter
	//////////////////////////////////////////////////

	assign cntZero = (cnt == '0);

	// A new divider restarts the count, so the next tick
	// lands a full period after the write
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= ResetDiv;
		end else if (cfgWrite) begin
			cnt <= cfgDiv;
		end else if (cntZero) begin
			cnt <= div;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// One-cycle pulse every div+1 cycles
	assign tick = cntZero;

endmodule

// ==== hdl/busPkg.sv ====
package busPkg;

	//////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////

	localparam int AddrWidth = 18;
	localparam int DataWidth = 16;
	localparam int PaceWidth = 4;

	typedef logic [AddrWidth-1:0] memAddrT;
	typedef logic [DataWidth-1:0] memValueT;
	typedef logic [PaceWidth-1:0] paceDivT;

	//////////////////////////////////////////////////
	// CPU access and chip pin groups
	//////////////////////////////////////////////////

	// One access from the CPU side, held until done
	typedef struct packed {
		logic rd;
		logic wr;
		memAddrT addr;
		memValueT value;
	} memReqT;

	// All active low
	typedef struct packed {
		logic en;
		logic oe;
		logic we;
	} sramPinsT;

	typedef struct packed {
		logic rdn;
		logic wrn;
	} uartPinsT;

	//////////////////////////////////////////////////
	// Controller steps
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		Idle    = 4'h0,
		UartRd1 = 4'h1,
		UartRd2 = 4'h2,
		UartRd3 = 4'h3,
		UartRd4 = 4'h4,
		UartWr1 = 4'h5,
		UartWr2 = 4'h6,
		UartWr3 = 4'h7,
		UartWr4 = 4'h8,
		UartWr5 = 4'h9,
		RamRd1  = 4'hA,
		RamRd3  = 4'hB,
		RamWr1  = 4'hC,
		RamWr2  = 4'hD,
		RamWr3  = 4'hE
	} busStateT;

endpackage

// ==== hdl/memUartBus.sv ====
module memUartBus #(
	parameter busPkg::memAddrT UartAddr = 18'h0BF00,
	parameter busPkg::paceDivT ResetDiv = 4'd1
) (
	input  logic clk,
	input  logic rst,

	// CPU side
	input  logic needToWork,
	input  busPkg::memReqT req,
	output logic workDone,
	output busPkg::memValueT result,
	output busPkg::busStateT state,

	// Pace configuration
	input  logic cfgWrite,
	input  busPkg::paceDivT cfgDiv,

	// Board pins
	output busPkg::memAddrT ramAddr,
	inout  wire busPkg::memValueT ramData,
	output busPkg::sramPinsT sramPins,
	output busPkg::uartPinsT uartPins,
	input  logic dataReady,
	input  logic tbre,
	input  logic tsre
);

	// Step pace, one pulse per step
	logic tick;

	//////////////////////////////////////////////////
	// Pace divider
	//////////////////////////////////////////////////

	busPaceRegs #(
		.ResetDiv(ResetDiv)
	) paceRegs (
		.clk(clk),
		.rst(rst),
		.cfgWrite(cfgWrite),
		.cfgDiv(cfgDiv),
		.tick(tick)
	);

	//////////////////////////////////////////////////
	// SRAM and UART sequencing
	//////////////////////////////////////////////////

	sramUartCtrl #(
		.UartAddr(UartAddr)
	) busCtrl (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.needToWork(needToWork),
		.req(req),
		.workDone(workDone),
		.result(result),
		.state(state),
		.ramAddr(ramAddr),
		.ramData(ramData),
		.sramPins(sramPins),
		.uartPins(uartPins),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

endmodule

// ==== hdl/sramUartCtrl.sv ====
module sramUartCtrl #(
	parameter busPkg::memAddrT UartAddr = 18'h0BF00
) (
	input  logic clk,
	input  logic rst,
	input  logic tick,

	input  logic needToWork,
	input  busPkg::memReqT req,
	output logic workDone,
	output busPkg::memValueT result,
	output busPkg::busStateT state,

	output busPkg::memAddrT ramAddr,
	inout  wire busPkg::memValueT ramData,
	output busPkg::sramPinsT sramPins,
	output busPkg::uartPinsT uartPins,
	input  logic dataReady,
	input  logic tbre,
	input  logic tsre
);

	import busPkg::*;

	busStateT nextState;
	logic isUart;
	logic startAccess;
	logic lastStep;
	logic captureNow;

	sramPinsT sramNext;
	uartPinsT uartNext;
	logic driveNext;
	logic driveBus;

	//////////////////////////////////////////////////
	// Address decode and bus drive
	//////////////////////////////////////////////////

	assign isUart = (req.addr == UartAddr);

	// Address goes straight to the chip
	assign ramAddr = req.addr;

	assign ramData = driveBus ? req.value : 'z;

	//////////////////////////////////////////////////
	// Step state machine
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (needToWork) begin
					if (isUart) begin
						if (req.wr) begin
							nextState = UartWr1;
						end else if (req.rd) begin
							nextState = UartRd1;
						end
					end else if (req.wr) begin
						nextState = RamWr1;
					end else begin
						nextState = RamRd1;
					end
				end
			end

			// Wait for a received byte
			UartRd1: begin
				if (dataReady) begin
					nextState = UartRd2;
				end
			end
			UartRd2: nextState = UartRd3;
			UartRd3: nextState = UartRd4;
			UartRd4: nextState = Idle;

			UartWr1: nextState = UartWr2;
			UartWr2: nextState = UartWr3;
			// Transmit buffer empty, then shift register empty
			UartWr3: begin
				if (tbre) begin
					nextState = UartWr4;
				end
			end
			UartWr4: begin
				if (tsre) begin
					nextState = UartWr5;
				end
			end
			UartWr5: nextState = Idle;

			RamRd1: nextState = RamRd3;
			RamRd3: nextState = Idle;

			RamWr1: nextState = RamWr2;
			RamWr2: nextState = RamWr3;
			RamWr3: nextState = Idle;

			default: nextState = Idle;
		endcase
	end

	assign startAccess = (state == Idle) && (nextState != Idle);

	assign lastStep = (state == UartRd4) || (state == UartWr5) ||
		(state == RamRd3) || (state == RamWr3);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= Idle;
		end else if (tick) begin
			state <= nextState;
		end
	end

	// Done sets on leaving the last step, clears on the next start
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			workDone <= 1'b0;
		end else if (tick) begin
			if (lastStep) begin
				workDone <= 1'b1;
			end else if (startAccess) begin
				workDone <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Chip pins from the current step
	//////////////////////////////////////////////////

	always_comb begin
		sramNext = '{en: 1'b1, oe: 1'b1, we: 1'b1};
		uartNext = '{rdn: 1'b1, wrn: 1'b1};
		driveNext = driveBus;
		case (state)
			// Release the bus before the UART drives it
			UartRd1: begin
				driveNext = 1'b0;
			end
			UartRd2, UartRd3: begin
				uartNext.rdn = 1'b0;
			end

			UartWr1: begin
				driveNext = 1'b1;
			end
			UartWr2: begin
				uartNext.wrn = 1'b0;
			end

			RamRd1: begin
				sramNext.en = 1'b0;
				sramNext.oe = 1'b0;
				driveNext = 1'b0;
			end
			RamRd3: begin
				sramNext.en = 1'b0;
				sramNext.oe = 1'b0;
			end

			RamWr1: begin
				sramNext.en = 1'b0;
				driveNext = 1'b1;
			end
			// Write strobe in the middle step only
			RamWr2: begin
				sramNext.en = 1'b0;
				sramNext.we = 1'b0;
			end
			RamWr3: begin
				sramNext.en = 1'b0;
			end

			default: begin
				driveNext = driveBus;
			end
		endcase
	end

	// Pins lag the state by one clock
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sramPins <= '{en: 1'b1, oe: 1'b1, we: 1'b1};
			uartPins <= '{rdn: 1'b1, wrn: 1'b1};
			driveBus <= 1'b0;
		end else begin
			sramPins <= sramNext;
			uartPins <= uartNext;
			driveBus <= driveNext;
		end
	end

	//////////////////////////////////////////////////
	// Read capture
	//////////////////////////////////////////////////

	assign captureNow = (state == UartRd3) || (state == RamRd3);

	// Samples the bus every clock of the capture step
	always_ff @(posedge clk) begin
		if (captureNow) begin
			result <= ramData;
		end
	end

endmodule

// ==== memUartBus.f ====
hdl/busPkg.sv
hdl/busPaceRegs.sv
hdl/sramUartCtrl.sv
hdl/memUartBus.sv
dv/chipModels.sv
dv/memUartBus_assertions.sv
dv/memUartBusTb.sv
